// File: logic/platform_cfg.svh
`ifndef PLATFORM_CFG_SVH
`define PLATFORM_CFG_SVH

// data ram depth in 32-bit words
`define PLAT_RAM_WORDS 256

// external interrupt sources
// 1 = button, 2 = uart frame done
`define PLAT_IRQ_SOURCES 2

// clock cycles per uart bit
`define PLAT_UART_DIV 8

// cycles the synchronized button must hold
// its new level before it is taken
`define PLAT_DEBOUNCE 4

`endif

// File: logic/platform_pkg.sv
`include "platform_cfg.svh"

package platform_pkg;

    // lower bound of each address region, top nibble of the address
    typedef enum logic [3:0] {
        RGN_TIMER  = 4'h2,  // below this is ram
        RGN_IRQ    = 4'h3,  // 3..7
        RGN_PERIPH = 4'h8   // 8 and up
    } region_e;

    typedef struct packed {
        logic [3:0]  region;
        logic [27:0] offset;
    } addr_fields_t;

    // one bus address, raw or split into region and offset
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } bus_addr_u;

    // zero means no source
    typedef logic [$clog2(`PLAT_IRQ_SOURCES + 1)-1:0] irq_id_t;

endpackage

// File: logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    en_i,
    input  platform_pkg::bus_addr_u addr_i,
    output logic                    ram_en_o,
    output logic                    rtc_en_o,
    output logic                    irq_en_o,
    output logic                    per_en_o,
    input  logic [31:0]             ram_rdata_i,
    input  logic [31:0]             rtc_rdata_i,
    input  logic [31:0]             irq_rdata_i,
    input  logic [31:0]             per_rdata_i,
    output logic [31:0]             rdata_o
);
    logic [3:0] region;
    logic       rtc_sel_q;
    logic       irq_sel_q;
    logic       per_sel_q;

    assign region = addr_i.f.region;

    //////////////////////////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ram_en_o = 1'b0;
        rtc_en_o = 1'b0;
        irq_en_o = 1'b0;
        per_en_o = 1'b0;
        if (en_i) begin
            if (region < platform_pkg::RGN_TIMER) begin
                ram_en_o = 1'b1;
            end else if (region < platform_pkg::RGN_IRQ) begin
                rtc_en_o = 1'b1;
            end else if (region < platform_pkg::RGN_PERIPH) begin
                irq_en_o = 1'b1;
            end else begin
                per_en_o = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // return path, one cycle behind the request
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rtc_sel_q <= 1'b0;
            irq_sel_q <= 1'b0;
            per_sel_q <= 1'b0;
        end else begin
            rtc_sel_q <= rtc_en_o;
            irq_sel_q <= irq_en_o;
            per_sel_q <= per_en_o;
        end
    end

    always_comb begin
        if (rtc_sel_q)      rdata_o = rtc_rdata_i;
        else if (irq_sel_q) rdata_o = irq_rdata_i;
        else if (per_sel_q) rdata_o = per_rdata_i;
        else                rdata_o = ram_rdata_i;  // ram also when idle
    end

    a_one_slave: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({ram_en_o, rtc_en_o, irq_en_o, per_en_o}));

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ps
`include "platform_cfg.svh"

module data_ram (
    input  logic                    clk,
    input  logic                    en_i,
    input  logic [3:0]              we_i,
    input  platform_pkg::bus_addr_u addr_i,
    input  logic [31:0]             wdata_i,
    output logic [31:0]             rdata_o
);
    localparam int AW = $clog2(`PLAT_RAM_WORDS);

    logic [31:0]   mem [0:`PLAT_RAM_WORDS-1];
    logic [AW-1:0] word;

    assign word = addr_i.f.offset[AW+1:2];  // byte offset to word index

    // byte lanes
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    mem[word][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // old word on a write cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[word];
        end
    end

endmodule

// File: logic/rtc_timer.sv
`timescale 1ns/1ps

module rtc_timer (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    en_i,
    input  logic [3:0]              we_i,
    input  platform_pkg::bus_addr_u addr_i,
    input  logic [31:0]             wdata_i,
    output logic [31:0]             rdata_o,
    output logic                    mti_o
);
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [2:0]  sel;
    logic        wr;

    // replace only the bytes selected by mask
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  mask);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign sel = addr_i.f.offset[4:2];
    assign wr  = en_i && (we_i != 4'b0000);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // no timer irq until programmed
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (wr) begin
                case (sel)
                    3'd0: mtime_q <= {mtime_q[63:32], merge_bytes(mtime_q[31:0], wdata_i, we_i)};
                    3'd1: mtime_q <= {merge_bytes(mtime_q[63:32], wdata_i, we_i), mtime_q[31:0]};
                    3'd2: mtimecmp_q[31:0]  <= merge_bytes(mtimecmp_q[31:0], wdata_i, we_i);
                    3'd3: mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], wdata_i, we_i);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (sel)
                3'd0:    rdata_o <= mtime_q[31:0];
                3'd1:    rdata_o <= mtime_q[63:32];
                3'd2:    rdata_o <= mtimecmp_q[31:0];
                3'd3:    rdata_o <= mtimecmp_q[63:32];
                default: rdata_o <= '0;
            endcase
        end
    end

    assign mti_o = (mtime_q >= mtimecmp_q);  // level

endmodule

// File: logic/irq_controller.sv
`timescale 1ns/1ps
`include "platform_cfg.svh"

module irq_controller (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         en_i,
    input  logic [3:0]                   we_i,
    input  platform_pkg::bus_addr_u      addr_i,
    input  logic [31:0]                  wdata_i,
    input  logic [`PLAT_IRQ_SOURCES:1]   irq_req_i,
    output logic [31:0]                  rdata_o,
    output logic                         mei_o,
    output logic [`PLAT_IRQ_SOURCES:1]   irq_ack_o
);
    localparam int N = `PLAT_IRQ_SOURCES;

    logic [N:1]            mask_q;
    logic [N:1]            pend;
    logic [2:0]            sel;
    logic                  wr;
    platform_pkg::irq_id_t claim_id;
    platform_pkg::irq_id_t done_id;

    assign sel     = addr_i.f.offset[4:2];
    assign wr      = en_i && (we_i != 4'b0000);
    assign done_id = wdata_i[$bits(platform_pkg::irq_id_t)-1:0];
    assign pend    = irq_req_i & mask_q;
    assign mei_o   = |pend;

    // lowest id wins
    always_comb begin
        claim_id = '0;
        for (int i = N; i >= 1; i--) begin
            if (pend[i]) claim_id = platform_pkg::irq_id_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mask_q    <= '0;
            irq_ack_o <= '0;
        end else begin
            irq_ack_o <= '0;  // single cycle pulse
            if (wr && sel == 3'd0) mask_q <= wdata_i[N:1];
            if (wr && sel == 3'd2) begin
                for (int i = 1; i <= N; i++) begin
                    if (done_id == platform_pkg::irq_id_t'(i)) irq_ack_o[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (sel)
                3'd0:    rdata_o <= {{(31-N){1'b0}}, mask_q, 1'b0};
                3'd1:    rdata_o <= {{(31-N){1'b0}}, irq_req_i, 1'b0};
                3'd2:    rdata_o <= 32'(claim_id);
                default: rdata_o <= '0;
            endcase
        end
    end

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(irq_ack_o));

endmodule

// File: logic/periph_block.sv
`timescale 1ns/1ps
`include "platform_cfg.svh"

module periph_block (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         en_i,
    input  logic [3:0]                   we_i,
    input  platform_pkg::bus_addr_u      addr_i,
    input  logic [31:0]                  wdata_i,
    input  logic                         button_i,
    input  logic [`PLAT_IRQ_SOURCES:1]   irq_ack_i,
    output logic [31:0]                  rdata_o,
    output logic [7:0]                   gpio_out_o,
    output logic [7:0]                   gpio_addr_o,
    output logic                         uart_tx_o,
    output logic [`PLAT_IRQ_SOURCES:1]   irq_req_o
);
    localparam int DB_W  = $clog2(`PLAT_DEBOUNCE + 1);
    localparam int DIV_W = $clog2(`PLAT_UART_DIV + 1);

    logic [2:0]                 sel;
    logic                       wr;
    logic                       btn_s1, btn_s2, btn_level;
    logic [DB_W-1:0]            db_cnt;
    logic                       db_done, btn_rise;
    logic                       busy;
    logic [8:0]                 shift_q;  // data bits then stop
    logic [3:0]                 bit_cnt;
    logic [DIV_W-1:0]           div_cnt;
    logic                       tx_q;
    logic                       bit_tick, uart_start, uart_done;
    logic [`PLAT_IRQ_SOURCES:1] req_set;

    assign sel = addr_i.f.offset[4:2];
    assign wr  = en_i && we_i[0];

    //////////////////////////////////////////////////////////////////////
    // gpio and button
    //////////////////////////////////////////////////////////////////////

    assign db_done  = (btn_s2 != btn_level) && (db_cnt == DB_W'(`PLAT_DEBOUNCE - 1));
    assign btn_rise = db_done && btn_s2;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            gpio_out_o  <= '0;
            gpio_addr_o <= '0;
            btn_s1      <= 1'b0;
            btn_s2      <= 1'b0;
            btn_level   <= 1'b0;
            db_cnt      <= '0;
        end else begin
            if (wr && sel == 3'd0) gpio_out_o  <= wdata_i[7:0];
            if (wr && sel == 3'd1) gpio_addr_o <= wdata_i[7:0];
            btn_s1 <= button_i;
            btn_s2 <= btn_s1;
            if (btn_s2 == btn_level) db_cnt <= '0;  // bounce restarts the count
            else if (db_done) begin
                btn_level <= btn_s2;
                db_cnt    <= '0;
            end else db_cnt <= db_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // uart 8n1 transmitter
    //////////////////////////////////////////////////////////////////////

    assign uart_start = wr && sel == 3'd3 && !busy;  // dropped while busy
    assign bit_tick   = busy && (div_cnt == DIV_W'(`PLAT_UART_DIV - 1));
    assign uart_done  = bit_tick && (bit_cnt == 4'd9);
    assign uart_tx_o  = tx_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy    <= 1'b0;
            tx_q    <= 1'b1;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (uart_start) begin
            busy    <= 1'b1;
            tx_q    <= 1'b0;  // start bit
            shift_q <= {1'b1, wdata_i[7:0]};
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (busy) begin
            div_cnt <= bit_tick ? '0 : div_cnt + 1'b1;
            if (uart_done) begin
                busy <= 1'b0;
                tx_q <= 1'b1;
            end else if (bit_tick) begin
                tx_q    <= shift_q[0];
                shift_q <= {1'b1, shift_q[8:1]};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // interrupt requests and readback
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        req_set    = '0;
        req_set[1] = btn_rise;
        req_set[2] = uart_done;
    end

    always_ff @(posedge clk) begin
        if (rst_i) irq_req_o <= '0;
        else       irq_req_o <= (irq_req_o & ~irq_ack_i) | req_set;  // new event beats ack
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (sel)
                3'd0:    rdata_o <= {24'h0, gpio_out_o};
                3'd1:    rdata_o <= {24'h0, gpio_addr_o};
                3'd2:    rdata_o <= {31'h0, btn_level};
                3'd4:    rdata_o <= {31'h0, busy};
                default: rdata_o <= '0;  // uart data is write only
            endcase
        end
    end

    a_tx_idle_high: assert property (@(posedge clk) disable iff (rst_i)
        !busy |-> uart_tx_o);

endmodule

// File: logic/soc_platform.sv
`timescale 1ns/1ps
`include "platform_cfg.svh"

module soc_platform (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        bus_en_i,
    input  logic [3:0]  bus_we_i,
    input  logic [31:0] bus_addr_i,
    input  logic [31:0] bus_wdata_i,
    input  logic        button_i,
    output logic [31:0] bus_rdata_o,
    output logic [7:0]  gpio_out_o,
    output logic [7:0]  gpio_addr_o,
    output logic        uart_tx_o,
    output logic        mti_o,
    output logic        mei_o
);
    platform_pkg::bus_addr_u    bus_addr;
    logic                       ram_en, rtc_en, irq_en, per_en;
    logic [31:0]                ram_rdata, rtc_rdata, irq_rdata, per_rdata;
    logic [`PLAT_IRQ_SOURCES:1] irq_req, irq_ack;

    assign bus_addr.raw = bus_addr_i;

    //////////////////////////////////////////////////////////////////////
    // decode and slaves
    //////////////////////////////////////////////////////////////////////

    bus_decoder bus_decoder_i (
        .clk(clk), .rst_i(rst_i), .en_i(bus_en_i), .addr_i(bus_addr),
        .ram_en_o(ram_en), .rtc_en_o(rtc_en), .irq_en_o(irq_en), .per_en_o(per_en),
        .ram_rdata_i(ram_rdata), .rtc_rdata_i(rtc_rdata),
        .irq_rdata_i(irq_rdata), .per_rdata_i(per_rdata),
        .rdata_o(bus_rdata_o)
    );

    data_ram data_ram_i (
        .clk(clk), .en_i(ram_en), .we_i(bus_we_i), .addr_i(bus_addr),
        .wdata_i(bus_wdata_i), .rdata_o(ram_rdata)
    );

    rtc_timer rtc_timer_i (
        .clk(clk), .rst_i(rst_i), .en_i(rtc_en), .we_i(bus_we_i), .addr_i(bus_addr),
        .wdata_i(bus_wdata_i), .rdata_o(rtc_rdata), .mti_o(mti_o)
    );

    irq_controller irq_controller_i (
        .clk(clk), .rst_i(rst_i), .en_i(irq_en), .we_i(bus_we_i), .addr_i(bus_addr),
        .wdata_i(bus_wdata_i), .irq_req_i(irq_req),
        .rdata_o(irq_rdata), .mei_o(mei_o), .irq_ack_o(irq_ack)
    );

    periph_block periph_block_i (
        .clk(clk), .rst_i(rst_i), .en_i(per_en), .we_i(bus_we_i), .addr_i(bus_addr),
        .wdata_i(bus_wdata_i), .button_i(button_i), .irq_ack_i(irq_ack),
        .rdata_o(per_rdata), .gpio_out_o(gpio_out_o), .gpio_addr_o(gpio_addr_o),
        .uart_tx_o(uart_tx_o), .irq_req_o(irq_req)
    );

endmodule

// File: sim/tb_soc_platform.sv
`timescale 1ns/1ps
`include "platform_cfg.svh"

module tb_soc_platform;
    localparam logic [31:0] RAM_BASE = 32'h0000_0000;
    localparam logic [31:0] RTC_BASE = 32'h2000_0000;
    localparam logic [31:0] IRQ_BASE = 32'h3000_0000;
    localparam logic [31:0] PER_BASE = 32'h8000_0000;
    localparam int BIT_CYC     = `PLAT_UART_DIV;
    localparam int BTN_CYC     = `PLAT_DEBOUNCE + 4;      // debounce plus sync, with margin
    localparam int TIMEOUT_CYC = 40 * 10 * BIT_CYC + 800; // frames plus all bus traffic

    logic        clk;
    logic        rst_i;
    logic        bus_en;
    logic [3:0]  bus_we;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        button;
    logic [31:0] bus_rdata;
    logic [7:0]  gpio_out;
    logic [7:0]  gpio_addr;
    logic        uart_tx;
    logic        mti;
    logic        mei;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] lcg_state = 32'h30a9_54cf;
    logic [31:0] ram_model [0:`PLAT_RAM_WORDS-1];

    soc_platform soc_platform_i (
        .clk(clk), .rst_i(rst_i), .bus_en_i(bus_en), .bus_we_i(bus_we),
        .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata), .button_i(button),
        .bus_rdata_o(bus_rdata), .gpio_out_o(gpio_out), .gpio_addr_o(gpio_addr),
        .uart_tx_o(uart_tx), .mti_o(mti), .mei_o(mei)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_id(input platform_pkg::irq_id_t got, input platform_pkg::irq_id_t exp,
                            input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus access, entered and left 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] we,
                             input logic [31:0] data);
        bus_en    = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = data;
        idle(1);
        bus_en = 1'b0;
        bus_we = 4'b0000;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_en   = 1'b1;
        bus_we   = 4'b0000;
        bus_addr = addr;
        idle(1);
        bus_en = 1'b0;
        data   = bus_rdata;  // one cycle after the request
    endtask

    // two reads in consecutive cycles
    task automatic read_pair(input logic [31:0] addr_a, input logic [31:0] addr_b,
                             output logic [31:0] data_a, output logic [31:0] data_b);
        bus_en   = 1'b1;
        bus_we   = 4'b0000;
        bus_addr = addr_a;
        idle(1);
        bus_addr = addr_b;
        data_a   = bus_rdata;
        idle(1);
        bus_en = 1'b0;
        data_b = bus_rdata;
    endtask

    task automatic check_pending(input logic [31:0] exp, input string msg);
        logic [31:0] rd;
        bus_read(IRQ_BASE + 32'd4, rd);
        check_word(rd, exp, msg);
    endtask

    task automatic claim_and_complete(input platform_pkg::irq_id_t exp);
        logic [31:0] rd;
        bus_read(IRQ_BASE + 32'd8, rd);
        check_id(platform_pkg::irq_id_t'(rd), exp, "claim id");
        bus_write(IRQ_BASE + 32'd8, 4'b1111, 32'(exp));
        idle(1);  // ack pulse, then request drops
    endtask

    // samples each bit in its middle
    task automatic capture_uart_frame(input logic [7:0] exp);
        logic [7:0] data;
        int         n;
        n = 0;
        while (uart_tx !== 1'b0 && n < 4 * BIT_CYC) begin
            idle(1);
            n++;
        end
        if (uart_tx !== 1'b0) begin
            errors++;
            $display("uart_tx never showed a start bit");
        end
        idle(BIT_CYC / 2);
        check_bit(uart_tx, 1'b0, "uart start bit");
        for (int b = 0; b < 8; b++) begin
            idle(BIT_CYC);
            data[b] = uart_tx;  // lsb first
        end
        idle(BIT_CYC);
        check_bit(uart_tx, 1'b1, "uart stop bit");
        check_byte(data, exp, "uart frame byte");
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_bit(mti, 1'b0, "mti after reset");
        check_bit(mei, 1'b0, "mei after reset");
        check_byte(gpio_out, 8'h00, "gpio_out after reset");
        check_byte(gpio_addr, 8'h00, "gpio_addr after reset");
        check_bit(uart_tx, 1'b1, "uart_tx idle after reset");
    endtask

    task automatic test_ram();
        int unsigned slot [16];
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] rd_per;
        logic [3:0]  mask;
        for (int i = 0; i < 16; i++) begin
            slot[i] = (rand_next() >> 8) % `PLAT_RAM_WORDS;
            data    = rand_next();
            ram_model[slot[i]] = data;
            bus_write(RAM_BASE + 32'(slot[i] * 4), 4'b1111, data);
        end
        for (int i = 0; i < 16; i++) begin
            data = rand_next();
            mask = data[3:0] == 4'b0000 ? 4'b0001 : data[3:0];
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) ram_model[slot[i]][8*b +: 8] = data[8*b +: 8];
            end
            bus_write(RAM_BASE + 32'(slot[i] * 4), mask, data);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(RAM_BASE + 32'(slot[i] * 4), rd);
            check_word(rd, ram_model[slot[i]], "ram readback");
        end
        // ram and peripheral reads interleaved
        bus_write(PER_BASE, 4'b0001, 32'h0000_005a);
        for (int i = 0; i < 4; i++) begin
            read_pair(RAM_BASE + 32'(slot[i] * 4), PER_BASE, rd, rd_per);
            check_word(rd, ram_model[slot[i]], "ram read before peripheral");
            check_word(rd_per, 32'h0000_005a, "peripheral read after ram");
        end
    endtask

    task automatic test_timer();
        logic [31:0] t0;
        logic [31:0] t1;
        int          n;
        bus_read(RTC_BASE, t0);
        idle(25);
        bus_read(RTC_BASE, t1);
        check_word(t1 - t0, 32'd26, "mtime step over 25 idle cycles");
        bus_read(RTC_BASE, t0);
        bus_write(RTC_BASE + 32'd12, 4'b1111, 32'h0000_0000);
        bus_write(RTC_BASE + 32'd8, 4'b1111, t0 + 32'd40);
        check_bit(mti, 1'b0, "mti before mtime reaches mtimecmp");
        n = 0;
        while (mti !== 1'b1 && n < 80) begin
            idle(1);
            n++;
        end
        if (mti !== 1'b1) begin
            errors++;
            $display("mti_o did not rise after mtime passed mtimecmp");
        end
        bus_read(RTC_BASE, t1);
        check_bit(t1 >= t0 + 32'd40, 1'b1, "mtime at or past mtimecmp when mti high");
        bus_write(RTC_BASE + 32'd8, 4'b1111, 32'hffff_ffff);
        bus_write(RTC_BASE + 32'd12, 4'b1111, 32'hffff_ffff);
        check_bit(mti, 1'b0, "mti after mtimecmp back to all ones");
    endtask

    task automatic test_gpio_uart();
        logic [31:0] rd;
        bus_write(PER_BASE, 4'b0001, 32'h0000_00c3);
        bus_write(PER_BASE + 32'd4, 4'b0001, 32'h0000_003c);
        check_byte(gpio_out, 8'hc3, "gpio_out pins");
        check_byte(gpio_addr, 8'h3c, "gpio_addr pins");
        bus_read(PER_BASE, rd);
        check_word(rd, 32'h0000_00c3, "gpio_out readback");
        bus_read(PER_BASE + 32'd4, rd);
        check_word(rd, 32'h0000_003c, "gpio_addr readback");
        bus_write(PER_BASE + 32'd12, 4'b0001, 32'h0000_00a5);
        fork
            capture_uart_frame(8'ha5);
            begin
                logic [31:0] busy;
                idle(20);
                bus_read(PER_BASE + 32'd16, busy);
                check_word(busy, 32'd1, "uart busy during frame");
                bus_write(PER_BASE + 32'd12, 4'b0001, 32'h0000_00ff);  // must be dropped
                bus_read(PER_BASE + 32'd16, busy);
                check_word(busy, 32'd1, "uart busy after write while busy");
            end
        join
        idle(BIT_CYC);
        bus_read(PER_BASE + 32'd16, rd);
        check_word(rd, 32'd0, "uart busy after frame");
        check_pending(32'h0000_0004, "uart done pending");
        bus_write(IRQ_BASE + 32'd8, 4'b1111, 32'd2);
        idle(1);
        check_pending(32'h0000_0000, "pending after completing uart");
    endtask

    task automatic test_irq();
        logic [31:0] rd;
        button = 1'b1;
        idle(BTN_CYC);
        check_bit(mei, 1'b0, "mei with mask zero");
        check_pending(32'h0000_0002, "button pending with mask zero");
        bus_read(PER_BASE + 32'd8, rd);
        check_word(rd, 32'd1, "debounced button level");
        button = 1'b0;
        idle(BTN_CYC);
        bus_write(IRQ_BASE, 4'b1111, 32'h0000_0006);
        check_bit(mei, 1'b1, "mei after mask enable");
        claim_and_complete(2'd1);
        check_bit(mei, 1'b0, "mei after completing button");
        check_pending(32'h0000_0000, "pending after completing button");
        bus_write(PER_BASE + 32'd12, 4'b0001, 32'h0000_003c);
        capture_uart_frame(8'h3c);
        idle(BIT_CYC);
        check_bit(mei, 1'b1, "mei after uart frame");
        claim_and_complete(2'd2);
        check_bit(mei, 1'b0, "mei after completing uart");
        // both sources pending together
        button = 1'b1;
        idle(BTN_CYC);
        button = 1'b0;
        bus_write(PER_BASE + 32'd12, 4'b0001, 32'h0000_0081);
        capture_uart_frame(8'h81);
        idle(BIT_CYC);
        check_pending(32'h0000_0006, "both sources pending");
        claim_and_complete(2'd1);
        claim_and_complete(2'd2);
        check_bit(mei, 1'b0, "mei after completing both");
    endtask

    initial begin
        rst_i     = 1'b1;
        bus_en    = 1'b0;
        bus_we    = 4'b0000;
        bus_addr  = '0;
        bus_wdata = '0;
        button    = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;
        idle(1);
        test_reset();
        test_ram();
        test_timer();
        test_gpio_uart();
        test_irq();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+logic
logic/platform_pkg.sv
logic/bus_decoder.sv
logic/data_ram.sv
logic/rtc_timer.sv
logic/irq_controller.sv
logic/periph_block.sv
logic/soc_platform.sv
sim/tb_soc_platform.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_soc_platform -o Vtb_soc_platform || exit 1
./obj_dir/Vtb_soc_platform > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
